//--- dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    ////////////////////////////////////////////////////////////
    // geometry: 16 sets x 2 ways x 4 words
    ////////////////////////////////////////////////////////////

    localparam int offset_width   = 2;  // word select inside a line
    localparam int index_width    = 4;  // set select
    localparam int tag_width      = 24; // remaining upper bits
    localparam int num_sets       = 16;
    localparam int words_per_line = 4;

    // byte address split
    //   [31:8] tag   [7:4] index   [3:2] word   [1:0] byte

    typedef logic [31:0]                     addr_t;
    typedef logic [31:0]                     word_t;
    typedef logic [3:0]                      strb_t;
    typedef logic [words_per_line*32-1:0]    line_t;
    typedef logic [tag_width-1:0]            tag_t;
    typedef logic [index_width-1:0]          index_t;
    typedef logic [offset_width-1:0]         offset_t;

endpackage

`default_nettype wire

//--- dcache_ctrl_pkg.sv
`default_nettype none

package dcache_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        idle,        // waiting for a request
        lookup,      // tag compare on the buffered request
        miss_r,      // line read issued, waiting for addr_ok
        miss_r_wait, // waiting for the refill line
        miss_w,      // write-through, waiting for addr_ok
        replace      // bubble after refill
    } state_t;

    // memory size codes on the mem_size port
    typedef logic [1:0] size_t;

    localparam size_t size_word = 2'd2; // single word write
    localparam size_t size_line = 2'd3; // whole line read

endpackage

`default_nettype wire

//--- dcache_req_buf.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_req_buf (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    rbuf_we,
    input  wire                    req_wr,
    input  dcache_geom_pkg::addr_t req_addr,
    input  dcache_geom_pkg::word_t req_wdata,
    input  dcache_geom_pkg::strb_t req_wstrb,
    output logic                   buf_wr,
    output dcache_geom_pkg::addr_t buf_addr,
    output dcache_geom_pkg::word_t buf_wdata,
    output dcache_geom_pkg::strb_t buf_wstrb
);

    ////////////////////////////////////////////////////////////
    // request hold register
    ////////////////////////////////////////////////////////////

    // loaded on the accept cycle only, so the fields stay put
    // for as long as a memory request is pending
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_wr    <= 1'b0;
            buf_addr  <= '0;
            buf_wdata <= '0;
            buf_wstrb <= '0;
        end else if (rbuf_we) begin
            buf_wr    <= req_wr;    // 1 = write
            buf_addr  <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

endmodule

`default_nettype wire

//--- dcache_lru.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_lru (
    input  wire                     clk,
    input  wire                     rstn,
    input  dcache_geom_pkg::index_t index,
    input  wire                     use_en,
    input  wire                     use_way,
    output logic                    victim
);

    // one bit per set, names the way to replace next
    logic [dcache_geom_pkg::num_sets-1:0] lru_bits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0; // way 0 goes first
        end else if (use_en) begin
            lru_bits[index] <= ~use_way; // point at the other way
        end
    end

    // combinational read for the buffered set
    assign victim = lru_bits[index];

endmodule

`default_nettype wire

//--- dcache_way.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_way (
    input  wire                      clk,
    input  wire                      rstn,
    input  dcache_geom_pkg::index_t  index,
    input  dcache_geom_pkg::tag_t    tag,
    input  dcache_geom_pkg::offset_t offset,
    input  wire                      we,
    input  wire                      refill,
    input  dcache_geom_pkg::line_t   refill_line,
    input  dcache_geom_pkg::word_t   wdata,
    input  dcache_geom_pkg::strb_t   wstrb,
    output logic                     hit,
    output dcache_geom_pkg::line_t   line
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    logic [dcache_geom_pkg::num_sets-1:0] valid;
    dcache_geom_pkg::tag_t                tags  [dcache_geom_pkg::num_sets];
    dcache_geom_pkg::line_t               lines [dcache_geom_pkg::num_sets];

    dcache_geom_pkg::line_t               merged_line; // hit line with strobed bytes

    // read side, combinational
    assign line = lines[index];
    assign hit  = valid[index] && (tags[index] == tag);

    // byte merge of the write word into the selected line
    always_comb begin
        merged_line = lines[index];
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged_line[(offset * 32) + (b * 8) +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (we && refill) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            if (refill) begin
                tags[index]  <= tag;          // new line from memory
                lines[index] <= refill_line;
            end else begin
                lines[index] <= merged_line;  // write hit
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl_fsm (
    input  wire                     clk,
    input  wire                     rstn,
    // pipeline side
    input  wire                     req_valid,
    output logic                    req_ready,
    output logic                    rbuf_we,
    output logic                    resp_valid,
    output logic                    choose_return,
    // buffered request
    input  wire                     buf_wr,
    input  dcache_geom_pkg::addr_t  buf_addr,
    // ways and lru
    input  wire                     hit0,
    input  wire                     hit1,
    input  wire                     victim,
    output logic [1:0]              way_we,
    output logic                    refill,
    output logic                    use_en,
    output logic                    use_way,
    // memory side
    input  wire                     mem_addr_ok,
    input  wire                     mem_data_ok,
    output logic                    mem_req,
    output logic                    mem_wr,
    output dcache_ctrl_pkg::size_t  mem_size,
    output dcache_geom_pkg::addr_t  mem_addr
);

    localparam int line_lsb = dcache_geom_pkg::offset_width + 2; // first index bit

    dcache_ctrl_pkg::state_t state;
    dcache_ctrl_pkg::state_t next_state;

    logic any_hit;

    assign any_hit = hit0 | hit1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= dcache_ctrl_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            dcache_ctrl_pkg::idle: begin
                if (req_valid) next_state = dcache_ctrl_pkg::lookup;
            end
            dcache_ctrl_pkg::lookup: begin
                if (buf_wr) begin
                    // write-through, done when memory takes it
                    if (!mem_addr_ok) next_state = dcache_ctrl_pkg::miss_w;
                    else if (req_valid) next_state = dcache_ctrl_pkg::lookup;
                    else next_state = dcache_ctrl_pkg::idle;
                end else if (any_hit) begin
                    if (req_valid) next_state = dcache_ctrl_pkg::lookup;
                    else next_state = dcache_ctrl_pkg::idle;
                end else begin
                    if (mem_addr_ok) next_state = dcache_ctrl_pkg::miss_r_wait;
                    else next_state = dcache_ctrl_pkg::miss_r;
                end
            end
            dcache_ctrl_pkg::miss_r: begin
                if (mem_addr_ok) next_state = dcache_ctrl_pkg::miss_r_wait;
            end
            dcache_ctrl_pkg::miss_r_wait: begin
                if (mem_data_ok) next_state = dcache_ctrl_pkg::replace;
            end
            dcache_ctrl_pkg::miss_w: begin
                if (mem_addr_ok) begin
                    if (req_valid) next_state = dcache_ctrl_pkg::lookup;
                    else next_state = dcache_ctrl_pkg::idle;
                end
            end
            dcache_ctrl_pkg::replace: next_state = dcache_ctrl_pkg::idle;
            default: next_state = dcache_ctrl_pkg::idle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // outputs from state and next state
    ////////////////////////////////////////////////////////////

    // fields held steady from the buffer while mem_req is up
    assign mem_size = buf_wr ? dcache_ctrl_pkg::size_word : dcache_ctrl_pkg::size_line;
    assign mem_addr = buf_wr ? {buf_addr[31:2], 2'b00}
                             : {buf_addr[31:line_lsb], {line_lsb{1'b0}}};

    always_comb begin
        req_ready     = 1'b0;
        rbuf_we       = 1'b0;
        resp_valid    = 1'b0;
        choose_return = 1'b0;
        mem_req       = 1'b0;
        mem_wr        = 1'b0;
        way_we        = 2'b00;
        refill        = 1'b0;
        use_en        = 1'b0;
        use_way       = 1'b0;
        case (state)
            dcache_ctrl_pkg::idle: begin
                req_ready = 1'b1;
                rbuf_we   = (next_state == dcache_ctrl_pkg::lookup);
            end
            dcache_ctrl_pkg::lookup: begin
                if (buf_wr) begin
                    mem_req = 1'b1;
                    mem_wr  = 1'b1;
                    way_we  = {hit1, hit0};  // merge only on a hit
                    use_en  = any_hit;
                    use_way = hit1;
                end else if (any_hit) begin
                    resp_valid = 1'b1;       // read hit answers now
                    use_en     = 1'b1;
                    use_way    = hit1;
                end else begin
                    mem_req = 1'b1;          // line read
                end
                // request finished this cycle, take the next one
                if (next_state == dcache_ctrl_pkg::lookup ||
                    next_state == dcache_ctrl_pkg::idle) begin
                    req_ready = 1'b1;
                    rbuf_we   = (next_state == dcache_ctrl_pkg::lookup);
                end
            end
            dcache_ctrl_pkg::miss_r: begin
                mem_req = 1'b1;
            end
            dcache_ctrl_pkg::miss_r_wait: begin
                if (next_state == dcache_ctrl_pkg::replace) begin
                    resp_valid    = 1'b1;
                    choose_return = 1'b1;    // forward from mem_rdata
                    refill        = 1'b1;
                    way_we        = victim ? 2'b10 : 2'b01;
                    use_en        = 1'b1;
                    use_way       = victim;
                end
            end
            dcache_ctrl_pkg::miss_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (next_state != dcache_ctrl_pkg::miss_w) begin
                    req_ready = 1'b1;
                    rbuf_we   = (next_state == dcache_ctrl_pkg::lookup);
                end
            end
            default: begin
                // replace is a bubble
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire                     clk,
    input  wire                     rstn,
    // pipeline side
    input  wire                     req_valid,
    output logic                    req_ready,
    input  wire                     req_wr,
    input  dcache_geom_pkg::addr_t  req_addr,
    input  dcache_geom_pkg::word_t  req_wdata,
    input  dcache_geom_pkg::strb_t  req_wstrb,
    output logic                    resp_valid,
    output dcache_geom_pkg::word_t  resp_rdata,
    // memory side
    output logic                    mem_req,
    output logic                    mem_wr,
    output dcache_ctrl_pkg::size_t  mem_size,
    output dcache_geom_pkg::addr_t  mem_addr,
    output dcache_geom_pkg::word_t  mem_wdata,
    output dcache_geom_pkg::strb_t  mem_wstrb,
    input  wire                     mem_addr_ok,
    input  wire                     mem_data_ok,
    input  dcache_geom_pkg::line_t  mem_rdata
);

    localparam int index_lsb = dcache_geom_pkg::offset_width + 2;

    logic                     rbuf_we;
    logic                     buf_wr;
    dcache_geom_pkg::addr_t   buf_addr;
    dcache_geom_pkg::word_t   buf_wdata;
    dcache_geom_pkg::strb_t   buf_wstrb;

    dcache_geom_pkg::tag_t    buf_tag;
    dcache_geom_pkg::index_t  buf_index;
    dcache_geom_pkg::offset_t buf_offset;

    logic                     hit0;
    logic                     hit1;
    dcache_geom_pkg::line_t   line0;
    dcache_geom_pkg::line_t   line1;
    dcache_geom_pkg::line_t   sel_line;
    logic [1:0]               way_we;
    logic                     refill;
    logic                     choose_return;
    logic                     use_en;
    logic                     use_way;
    logic                     victim;

    // split of the buffered address
    assign buf_offset = buf_addr[2 +: dcache_geom_pkg::offset_width];
    assign buf_index  = buf_addr[index_lsb +: dcache_geom_pkg::index_width];
    assign buf_tag    = buf_addr[31 -: dcache_geom_pkg::tag_width];

    dcache_req_buf u_req_buf (
        .clk(clk), .rstn(rstn), .rbuf_we(rbuf_we),
        .req_wr(req_wr), .req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .buf_wr(buf_wr), .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb)
    );

    dcache_way u_way0 (
        .clk(clk), .rstn(rstn), .index(buf_index), .tag(buf_tag), .offset(buf_offset),
        .we(way_we[0]), .refill(refill), .refill_line(mem_rdata),
        .wdata(buf_wdata), .wstrb(buf_wstrb), .hit(hit0), .line(line0)
    );

    dcache_way u_way1 (
        .clk(clk), .rstn(rstn), .index(buf_index), .tag(buf_tag), .offset(buf_offset),
        .we(way_we[1]), .refill(refill), .refill_line(mem_rdata),
        .wdata(buf_wdata), .wstrb(buf_wstrb), .hit(hit1), .line(line1)
    );

    dcache_lru u_lru (
        .clk(clk), .rstn(rstn), .index(buf_index),
        .use_en(use_en), .use_way(use_way), .victim(victim)
    );

    dcache_ctrl_fsm u_ctrl (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_ready(req_ready), .rbuf_we(rbuf_we),
        .resp_valid(resp_valid), .choose_return(choose_return),
        .buf_wr(buf_wr), .buf_addr(buf_addr),
        .hit0(hit0), .hit1(hit1), .victim(victim),
        .way_we(way_we), .refill(refill), .use_en(use_en), .use_way(use_way),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_size(mem_size), .mem_addr(mem_addr)
    );

    ////////////////////////////////////////////////////////////
    // response word select
    ////////////////////////////////////////////////////////////

    assign sel_line   = choose_return ? mem_rdata : (hit1 ? line1 : line0);
    assign resp_rdata = sel_line[buf_offset * 32 +: 32];

    // write-through payload straight from the buffer
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

endmodule

`default_nettype wire

//--- tb_dcache_props.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_props (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    req_ready,
    input  wire                    resp_valid,
    input  wire                    mem_req,
    input  wire                    mem_wr,
    input  dcache_ctrl_pkg::size_t mem_size,
    input  dcache_geom_pkg::addr_t mem_addr,
    input  dcache_geom_pkg::word_t mem_wdata,
    input  dcache_geom_pkg::strb_t mem_wstrb,
    input  wire                    mem_addr_ok,
    input  wire                    mem_data_ok
);

    // request held with steady fields until memory takes it
    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_size)
            && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_wstrb))
        else $error("mem_req dropped or changed before mem_addr_ok");

    a_no_req_in_reset: assert property (@(posedge clk) !rstn |-> !mem_req)
        else $error("mem_req high during reset");

    // busy and answering only makes sense on the refill beat
    a_resp_when_busy: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid && !req_ready |-> mem_data_ok)
        else $error("resp_valid with req_ready low outside a refill");

endmodule

bind dcache_top tb_dcache_props u_props (.*);

`default_nettype wire

//--- tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    typedef struct packed {
        logic                   wr;
        dcache_geom_pkg::addr_t addr;
        dcache_geom_pkg::word_t data;
        dcache_geom_pkg::strb_t strb;
    } mem_op_t;

    localparam int wait_limit = 50; // cycles before any wait gives up

    logic                   clk;
    logic                   rstn;
    logic                   req_valid, req_ready, req_wr;
    dcache_geom_pkg::addr_t req_addr;
    dcache_geom_pkg::word_t req_wdata;
    dcache_geom_pkg::strb_t req_wstrb;
    logic                   resp_valid;
    dcache_geom_pkg::word_t resp_rdata;
    logic                   mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    dcache_ctrl_pkg::size_t mem_size;
    dcache_geom_pkg::addr_t mem_addr;
    dcache_geom_pkg::word_t mem_wdata;
    dcache_geom_pkg::strb_t mem_wstrb;
    dcache_geom_pkg::line_t mem_rdata;

    integer seed = 78;
    int     error_count = 0, check_count = 0;
    int     read_count = 0, write_count = 0, resp_count = 0;
    logic   timed_out = 1'b0;

    // reference memory in request order, and the responder's own copy
    dcache_geom_pkg::word_t ref_mem [256];
    dcache_geom_pkg::word_t mem_words [256];

    // cache model with tags, valid bits and lru for two ways
    dcache_geom_pkg::tag_t  model_tag [2][dcache_geom_pkg::num_sets];
    logic                   model_valid [2][dcache_geom_pkg::num_sets];
    logic                   model_lru [dcache_geom_pkg::num_sets];

    dcache_geom_pkg::word_t resp_q [$]; // expected read data in order
    mem_op_t                op_q [$];   // expected memory requests
    logic                   hit_due = 1'b0, miss_due = 1'b0, rd_pending = 1'b0;
    int                     addr_delay, data_delay = 0;
    logic [5:0]             rd_line;

    dcache_top u_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic dcache_geom_pkg::word_t fill_word(input int idx);
        return 32'h5a00_0000 ^ (idx * 32'h0001_0101);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////////////////////////

    initial begin : responder
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        addr_delay  = {$random(seed)} % 4;
        forever begin
            @(posedge clk);
            if (rstn && mem_req && mem_addr_ok) begin
                if (mem_wr) begin
                    for (int b = 0; b < 4; b++)
                        if (mem_wstrb[b]) mem_words[mem_addr[9:2]][b*8 +: 8] = mem_wdata[b*8 +: 8];
                end else begin
                    rd_line    = mem_addr[9:4];
                    data_delay = 1 + {$random(seed)} % 4; // data_ok 1..4 cycles later
                end
                addr_delay = {$random(seed)} % 4;  // for the next request
            end
            @(negedge clk);
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (data_delay > 0) begin
                data_delay--;
                if (data_delay == 0) begin
                    mem_data_ok = 1'b1;
                    for (int w = 0; w < 4; w++)
                        mem_rdata[w*32 +: 32] = mem_words[{rd_line, w[1:0]}];
                end
            end else if (mem_req && addr_delay == 0) begin
                mem_addr_ok = 1'b1;
            end else if (mem_req) begin
                addr_delay--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // model and monitor
    ////////////////////////////////////////////////////////////

    task automatic model_accept();
        int idx;
        int widx;
        int way;
        idx  = req_addr[7:4];
        widx = req_addr[9:2];
        way  = -1;
        for (int w = 0; w < 2; w++)
            if (model_valid[w][idx] && model_tag[w][idx] == req_addr[31:8]) way = w;
        if (req_wr) begin
            write_count++;
            if (way >= 0) model_lru[idx] = (way == 0); // write hit touches lru too
            for (int b = 0; b < 4; b++)
                if (req_wstrb[b]) ref_mem[widx][b*8 +: 8] = req_wdata[b*8 +: 8];
            op_q.push_back({1'b1, req_addr[31:2], 2'b00, req_wdata, req_wstrb});
        end else begin
            read_count++;
            if (way >= 0) begin
                hit_due        = 1'b1;
                model_lru[idx] = (way == 0);
            end else begin
                miss_due               = 1'b1;
                way                    = model_lru[idx]; // victim
                model_tag[way][idx]    = req_addr[31:8];
                model_valid[way][idx]  = 1'b1;
                model_lru[idx]         = (way == 0);
                op_q.push_back({1'b0, req_addr[31:4], 4'h0, 32'h0, 4'h0});
            end
            resp_q.push_back(ref_mem[widx]);
        end
    endtask

    always @(posedge clk) begin : monitor
        mem_op_t op;
        logic    hit_now;
        if (rstn) begin
            hit_now = hit_due;
            if (hit_due) begin
                check_eq("resp_valid", resp_valid, 1'b1);
                check_eq("mem_req", mem_req, 1'b0);
            end
            if (miss_due) check_eq("mem_req", mem_req, 1'b1);
            hit_due  = 1'b0;
            miss_due = 1'b0;
            if ((mem_req && !mem_addr_ok) || rd_pending) check_eq("req_ready", req_ready, 1'b0);
            if (mem_data_ok) rd_pending = 1'b0;
            if (mem_req && mem_addr_ok) begin
                if (op_q.size() == 0) begin
                    error_count++;
                    $display("memory request at %0t ns that no request asked for", $time);
                end else begin
                    op = op_q.pop_front();
                    check_eq("mem_wr", mem_wr, op.wr);
                    check_eq("mem_size", mem_size,
                             op.wr ? dcache_ctrl_pkg::size_word : dcache_ctrl_pkg::size_line);
                    check_eq("mem_addr", mem_addr, op.addr);
                    if (op.wr) begin
                        check_eq("mem_wdata", mem_wdata, op.data);
                        check_eq("mem_wstrb", mem_wstrb, op.strb);
                    end else begin
                        rd_pending = 1'b1;
                    end
                end
            end
            if (resp_valid) begin
                resp_count++;
                if (!hit_now) check_eq("mem_data_ok", mem_data_ok, 1'b1); // miss answers on refill
                if (resp_q.size() == 0) begin
                    error_count++;
                    $display("response at %0t ns with no read outstanding", $time);
                end else begin
                    check_eq("resp_rdata", resp_rdata, resp_q.pop_front());
                end
            end
            if (req_valid && req_ready) model_accept();
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic issue_request(input int wr_pct);
        int wait_cycles;
        @(negedge clk);
        if ({$random(seed)} % 4 == 0) begin
            req_valid = 1'b0;   // idle gap now and then
            @(negedge clk);
        end
        req_valid = 1'b1;
        req_wr    = ({$random(seed)} % 100) < wr_pct;
        req_addr  = $random(seed) & 32'h0000_03ff; // 1 KB window
        req_wdata = $random(seed);
        req_wstrb = $random(seed);
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!req_ready && wait_cycles < wait_limit);
        if (!req_ready) begin
            timed_out = 1'b1;
            error_count++;
            $display("timeout: request not accepted within %0d cycles", wait_limit);
        end
    endtask

    task automatic drain();
        int wait_cycles;
        @(negedge clk);
        req_valid   = 1'b0;
        wait_cycles = 0;
        while ((resp_q.size() != 0 || op_q.size() != 0 || !req_ready) &&
               wait_cycles < wait_limit) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (wait_cycles >= wait_limit) begin
            timed_out = 1'b1;
            error_count++;
            $display("timeout: cache did not finish its outstanding work");
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %s", name, (error_count == errors_before) ? "ok" : "errors found");
    endtask

    task automatic run_phase(input string name, input int n, input int wr_pct);
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < n && !timed_out; i++)
            issue_request(wr_pct);
        drain();
        report_test(name, errors_before);
    endtask

    initial begin : main
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_wr    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]   = fill_word(i);
            mem_words[i] = fill_word(i);
        end
        for (int s = 0; s < dcache_geom_pkg::num_sets; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_eq("req_ready", req_ready, 1'b1);
        check_eq("mem_req", mem_req, 1'b0);
        check_eq("resp_valid", resp_valid, 1'b0);
        report_test("reset state", 0);
        run_phase("cold reads", 40, 0);
        run_phase("mixed traffic", 300, 50);
        run_phase("write heavy", 200, 75);
        check_eq("response count", resp_count, read_count);
        $display("done: %0d checks, %0d errors, %0d reads, %0d writes, %0d responses",
                 check_count, error_count, read_count, write_count, resp_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
dcache_geom_pkg.sv
dcache_ctrl_pkg.sv
dcache_req_buf.sv
dcache_lru.sv
dcache_way.sv
dcache_ctrl_fsm.sv
dcache_top.sv
tb_dcache_props.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  # design, packages first
  - dcache_geom_pkg.sv
  - dcache_ctrl_pkg.sv
  - dcache_req_buf.sv
  - dcache_lru.sv
  - dcache_way.sv
  - dcache_ctrl_fsm.sv
  - dcache_top.sv
  # testbench
  - target: test
    files:
      - tb_dcache_props.sv
      - tb_dcache.sv
